// File: design/addr_slice.sv
`timescale 1ns/1ns

module addr_slice
   #(parameter type payload_t = logic)
   (input  logic      clk_i
    , input  logic     rst_n_i

    , input  logic     in_valid_i
    , output logic     in_ready_o
    , input  payload_t in_data_i

    , output logic     out_valid_o
    , input  logic     out_ready_i
    , output payload_t out_data_o
    );

   payload_t   mem_r [2];
   logic [1:0] count_r;
   logic [1:0] count_n;
   logic       wr_ptr_r;
   logic       rd_ptr_r;
   logic       ready_r;
   logic       push;
   logic       pop;

   assign push = in_valid_i & ready_r;
   assign pop  = out_valid_o & out_ready_i;

   assign count_n = count_r + {1'b0, push} - {1'b0, pop};

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         count_r  <= '0;
         wr_ptr_r <= 1'b0;
         rd_ptr_r <= 1'b0;
         ready_r  <= 1'b1;
      end else begin
         count_r <= count_n;
         // ready only drops once both entries hold data
         ready_r <= (count_n != 2'd2);
         if (push)
            wr_ptr_r <= ~wr_ptr_r;
         if (pop)
            rd_ptr_r <= ~rd_ptr_r;
      end
   end

   always_ff @(posedge clk_i) begin
      if (push)
         mem_r[wr_ptr_r] <= in_data_i;
   end

   assign in_ready_o  = ready_r;
   assign out_valid_o = (count_r != 2'd0);
   assign out_data_o  = mem_r[rd_ptr_r];

   // a stalled output keeps its entry
   assert property (@(posedge clk_i) disable iff (!rst_n_i)
      out_valid_o && !out_ready_i |=> out_valid_o && (out_data_o == $past(out_data_o)));

endmodule

// File: design/dram_cfg_if.sv
`timescale 1ns/1ns

interface dram_cfg_if
   import zynq_shell_pkg::*;
   ();

   // PS allocated DRAM base and the flag that it is valid
   logic [bp_addr_width_lp-1:0]   dram_base;
   logic                          dram_valid;

   // accelerator reset, low true
   logic                          accel_reset_n;

   // touched region bitmap
   logic [profile_regions_lp-1:0] profile;

   modport csr (
      output dram_base
      , output dram_valid
      , output accel_reset_n
      , input  profile
   );

   modport dram (
      input    dram_base
      , input  dram_valid
      , input  accel_reset_n
      , output profile
   );

endinterface

// File: design/dram_rebase.sv
`timescale 1ns/1ns

module dram_rebase
   import zynq_shell_pkg::*;
   (input  logic     clk_i
    , input  logic    rst_n_i

    , input  logic    req_valid_i
    , output logic    req_ready_o
    , input  bp_req_t req_i

    , output logic    hp_valid_o
    , input  logic    hp_ready_i
    , output bp_req_t hp_req_o

    , dram_cfg_if.dram cfg
    );

   bp_req_t rebased_req;
   logic    slice_ready;
   logic    accept;

   // nothing goes out until the PS has allocated DRAM
   assign req_ready_o = slice_ready & cfg.dram_valid;
   assign accept      = req_valid_i & req_ready_o;

   // the slice captures the base in force at acceptance
   assign rebased_req.addr  = (req_i.addr ^ dram_flip_lp) + cfg.dram_base;
   assign rebased_req.write = req_i.write;

   addr_slice
      #(.payload_t(bp_req_t))
      u_slice
      (.clk_i       (clk_i)
       ,.rst_n_i    (rst_n_i)
       ,.in_valid_i (req_valid_i & cfg.dram_valid)
       ,.in_ready_o (slice_ready)
       ,.in_data_i  (rebased_req)
       ,.out_valid_o(hp_valid_o)
       ,.out_ready_i(hp_ready_i)
       ,.out_data_o (hp_req_o)
       );

   // profile the accelerator view of the address
   mem_profiler u_profiler
      (.clk_i   (clk_i)
       ,.rst_n_i(rst_n_i)
       ,.hit_i  (accept)
       ,.addr_i (req_i.addr)
       ,.cfg    (cfg)
       );

endmodule

// File: design/host_window.sv
`timescale 1ns/1ns

module host_window
   import zynq_shell_pkg::*;
   (input  logic       clk_i
    , input  logic      rst_n_i

    , input  logic      host_valid_i
    , output logic      host_ready_o
    , input  host_req_t host_req_i

    , output logic      acc_valid_o
    , input  logic      acc_ready_i
    , output bp_req_t   acc_req_o
    );

   bp_req_t xlat_req;

   // window 0 lands in accelerator DRAM at 0x8000_0000
   // window 2 lands in accelerator local space at 0x0000_0000
   assign xlat_req.addr  = {~host_req_i.addr[29], 3'b000, host_req_i.addr[27:0]};
   assign xlat_req.write = host_req_i.write;

   addr_slice
      #(.payload_t(bp_req_t))
      u_slice
      (.clk_i       (clk_i)
       ,.rst_n_i    (rst_n_i)
       ,.in_valid_i (host_valid_i)
       ,.in_ready_o (host_ready_o)
       ,.in_data_i  (xlat_req)
       ,.out_valid_o(acc_valid_o)
       ,.out_ready_i(acc_ready_i)
       ,.out_data_o (acc_req_o)
       );

endmodule

// File: design/mem_profiler.sv
`timescale 1ns/1ns

module mem_profiler
   import zynq_shell_pkg::*;
   (input  logic                         clk_i
    , input  logic                        rst_n_i
    , input  logic                        hit_i
    , input  logic [bp_addr_width_lp-1:0] addr_i
    , dram_cfg_if.dram                    cfg
    );

   logic [profile_regions_lp-1:0]   profile_r;
   logic [profile_idx_width_lp-1:0] region;

   // 8 MB regions, upper address bits above 29 are not tracked
   assign region = addr_i[profile_lsb_lp +: profile_idx_width_lp];

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         profile_r <= '0;
      end else if (!cfg.accel_reset_n) begin
         // a fresh run starts with an empty map
         profile_r <= '0;
      end else if (hit_i) begin
         profile_r[region] <= 1'b1;
      end
   end

   assign cfg.profile = profile_r;

   // once the accelerator has sat in reset for a cycle the map is empty
   assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !$past(cfg.accel_reset_n) |-> (cfg.profile == '0));

endmodule

// File: design/shell_csr.sv
`timescale 1ns/1ns

module shell_csr
   import zynq_shell_pkg::*;
   (input  logic                          clk_i
    , input  logic                         rst_n_i

    , input  logic                         csr_req_valid_i
    , input  logic                         csr_req_write_i
    , input  logic [csr_addr_width_lp-1:0] csr_req_addr_i
    , input  logic [csr_data_width_lp-1:0] csr_req_wdata_i
    , output logic                         csr_req_ready_o

    , output logic                         csr_resp_valid_o
    , output logic [csr_data_width_lp-1:0] csr_resp_data_o
    , input  logic                         csr_resp_ready_i

    , dram_cfg_if.csr                      cfg
    );

   logic                                                accel_reset_n_r;
   logic                                                dram_valid_r;
   logic [bp_addr_width_lp-1:0]                         dram_base_r;
   logic                                                resp_valid_r;
   logic [csr_data_width_lp-1:0]                        resp_data_r;
   logic [csr_data_width_lp-1:0]                        rdata;
   logic [profile_words_lp-1:0][csr_data_width_lp-1:0] profile_words;
   logic [profile_sel_width_lp-1:0]                     profile_sel;
   logic                                                req_accept;

   assign csr_req_ready_o = ~resp_valid_r;
   assign req_accept      = csr_req_valid_i & csr_req_ready_o;

   // word 0 holds the lowest regions
   assign profile_words = cfg.profile;
   assign profile_sel   = profile_sel_width_lp'(csr_req_addr_i - csr_profile_idx_lp);

   always_comb begin
      rdata = '0;
      case (csr_req_addr_i)
         csr_reset_idx_lp:      rdata[0] = accel_reset_n_r;
         csr_dram_valid_idx_lp: rdata[0] = dram_valid_r;
         csr_dram_base_idx_lp:  rdata = dram_base_r;
         default: begin
            if (csr_req_addr_i >= csr_profile_idx_lp
                && csr_req_addr_i < csr_profile_idx_lp + profile_words_lp)
               rdata = profile_words[profile_sel];
         end
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         accel_reset_n_r <= 1'b0;
         dram_valid_r    <= 1'b0;
         dram_base_r     <= '0;
         resp_valid_r    <= 1'b0;
      end else begin
         if (req_accept) begin
            resp_valid_r <= 1'b1;
         end else if (csr_resp_ready_i) begin
            resp_valid_r <= 1'b0;
         end
         // writes past the base register land nowhere
         if (req_accept && csr_req_write_i) begin
            case (csr_req_addr_i)
               csr_reset_idx_lp:      accel_reset_n_r <= csr_req_wdata_i[0];
               csr_dram_valid_idx_lp: dram_valid_r    <= csr_req_wdata_i[0];
               csr_dram_base_idx_lp:  dram_base_r     <= csr_req_wdata_i;
               default: ;
            endcase
         end
      end
   end

   // writes answer with zero
   always_ff @(posedge clk_i) begin
      if (req_accept)
         resp_data_r <= csr_req_write_i ? '0 : rdata;
   end

   assign csr_resp_valid_o = resp_valid_r;
   assign csr_resp_data_o  = resp_data_r;

   assign cfg.accel_reset_n = accel_reset_n_r;
   assign cfg.dram_valid    = dram_valid_r;
   assign cfg.dram_base     = dram_base_r;

   // a second request waits for the response handshake
   assert property (@(posedge clk_i) disable iff (!rst_n_i)
      req_accept |=> csr_resp_valid_o && !req_accept);

endmodule

// File: design/zynq_shell_pkg.sv
package zynq_shell_pkg;

   // the PS drops the top two bits of the host window address
   localparam int host_addr_width_lp = 30;

   // accelerator physical and PS DRAM addresses
   localparam int bp_addr_width_lp = 32;

   // register bus
   localparam int csr_data_width_lp = 32;
   localparam int csr_addr_width_lp = 3;

   // register word indices
   localparam logic [csr_addr_width_lp-1:0] csr_reset_idx_lp      = 3'd0;
   localparam logic [csr_addr_width_lp-1:0] csr_dram_valid_idx_lp = 3'd1;
   localparam logic [csr_addr_width_lp-1:0] csr_dram_base_idx_lp  = 3'd2;
   // first of the profile words, the rest follow in order
   localparam logic [csr_addr_width_lp-1:0] csr_profile_idx_lp    = 3'd3;

   // accelerator DRAM starts here, removed with an xor
   localparam logic [bp_addr_width_lp-1:0] dram_flip_lp = 32'h8000_0000;

   // one profile bit per 8 MB region
   localparam int profile_regions_lp = 128;
   localparam int profile_lsb_lp = 23;
   localparam int profile_idx_width_lp = $clog2(profile_regions_lp);

   // profile as seen through the register bus
   localparam int profile_words_lp = profile_regions_lp / csr_data_width_lp;
   localparam int profile_sel_width_lp = $clog2(profile_words_lp);

   // request from the PS general purpose window
   typedef struct packed {
      logic [host_addr_width_lp-1:0] addr;
      logic                          write;
   } host_req_t;

   // request in accelerator or PS DRAM address space
   typedef struct packed {
      logic [bp_addr_width_lp-1:0] addr;
      logic                        write;
   } bp_req_t;

endpackage

// File: design/zynq_shell_top.sv
`timescale 1ns/1ns

module zynq_shell_top
   import zynq_shell_pkg::*;
   (input  logic                          clk_i
    , input  logic                         rst_n_i

    // PS register bus
    , input  logic                         csr_req_valid_i
    , input  logic                         csr_req_write_i
    , input  logic [csr_addr_width_lp-1:0] csr_req_addr_i
    , input  logic [csr_data_width_lp-1:0] csr_req_wdata_i
    , output logic                         csr_req_ready_o
    , output logic                         csr_resp_valid_o
    , output logic [csr_data_width_lp-1:0] csr_resp_data_o
    , input  logic                         csr_resp_ready_i

    // PS general purpose window
    , input  logic                          host_valid_i
    , input  logic [host_addr_width_lp-1:0] host_addr_i
    , input  logic                          host_write_i
    , output logic                          host_ready_o

    // translated host requests into the accelerator
    , output logic                        acc_valid_o
    , output logic [bp_addr_width_lp-1:0] acc_addr_o
    , output logic                        acc_write_o
    , input  logic                        acc_ready_i

    // accelerator DRAM requests
    , input  logic                        dram_req_valid_i
    , input  logic [bp_addr_width_lp-1:0] dram_req_addr_i
    , input  logic                        dram_req_write_i
    , output logic                        dram_req_ready_o

    // rebased requests to the PS HP port
    , output logic                        hp_valid_o
    , output logic [bp_addr_width_lp-1:0] hp_addr_o
    , output logic                        hp_write_o
    , input  logic                        hp_ready_i

    , output logic                        accel_reset_n_o
    );

   host_req_t host_req;
   bp_req_t   acc_req;
   bp_req_t   dram_req;
   bp_req_t   hp_req;

   dram_cfg_if u_cfg ();

   assign host_req = '{addr: host_addr_i, write: host_write_i};
   assign dram_req = '{addr: dram_req_addr_i, write: dram_req_write_i};

   assign acc_addr_o  = acc_req.addr;
   assign acc_write_o = acc_req.write;
   assign hp_addr_o   = hp_req.addr;
   assign hp_write_o  = hp_req.write;

   assign accel_reset_n_o = u_cfg.accel_reset_n;

   shell_csr u_csr
      (.clk_i            (clk_i)
       ,.rst_n_i         (rst_n_i)
       ,.csr_req_valid_i (csr_req_valid_i)
       ,.csr_req_write_i (csr_req_write_i)
       ,.csr_req_addr_i  (csr_req_addr_i)
       ,.csr_req_wdata_i (csr_req_wdata_i)
       ,.csr_req_ready_o (csr_req_ready_o)
       ,.csr_resp_valid_o(csr_resp_valid_o)
       ,.csr_resp_data_o (csr_resp_data_o)
       ,.csr_resp_ready_i(csr_resp_ready_i)
       ,.cfg             (u_cfg)
       );

   host_window u_host_window
      (.clk_i        (clk_i)
       ,.rst_n_i     (rst_n_i)
       ,.host_valid_i(host_valid_i)
       ,.host_ready_o(host_ready_o)
       ,.host_req_i  (host_req)
       ,.acc_valid_o (acc_valid_o)
       ,.acc_ready_i (acc_ready_i)
       ,.acc_req_o   (acc_req)
       );

   dram_rebase u_dram_rebase
      (.clk_i       (clk_i)
       ,.rst_n_i    (rst_n_i)
       ,.req_valid_i(dram_req_valid_i)
       ,.req_ready_o(dram_req_ready_o)
       ,.req_i      (dram_req)
       ,.hp_valid_o (hp_valid_o)
       ,.hp_ready_i (hp_ready_i)
       ,.hp_req_o   (hp_req)
       ,.cfg        (u_cfg)
       );

endmodule

// File: list.f
design/zynq_shell_pkg.sv
design/dram_cfg_if.sv
design/addr_slice.sv
design/host_window.sv
design/mem_profiler.sv
design/dram_rebase.sv
design/shell_csr.sv
design/zynq_shell_top.sv
tb/tb_zynq_shell.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run, then look for the fail message in the log
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ns --top-module tb_zynq_shell \
   -f list.f -o tb_zynq_shell \
   && ./obj_dir/tb_zynq_shell > sim.log 2>&1 \
   && cat sim.log \
   && ! grep -qF "*** TEST FAILED ***" sim.log \
   || { [ -f sim.log ] && cat sim.log; echo "simulation failed"; exit 1; }
echo "simulation passed"

// File: tb/tb_zynq_shell.sv
`timescale 1ns/1ns

module tb_zynq_shell
   import zynq_shell_pkg::*;
   ();

   localparam int n_csr_lp   = 24;
   localparam int n_host_lp  = 200;
   localparam int n_dram_lp  = 200;
   localparam int n_burst_lp = 4;
   // summed rough cycle counts of the tests
   localparam int len_lp = 10 + n_csr_lp * 8 + n_host_lp * 3 + n_dram_lp * 3 + 60 + 60;
   localparam int timeout_lp = len_lp * 4 + 200;

   logic clk_i;
   logic rst_n_i;
   logic csr_req_valid_i, csr_req_write_i, csr_req_ready_o;
   logic csr_resp_valid_o, csr_resp_ready_i;
   logic [csr_addr_width_lp-1:0] csr_req_addr_i;
   logic [csr_data_width_lp-1:0] csr_req_wdata_i, csr_resp_data_o;
   logic host_valid_i, host_write_i, host_ready_o;
   logic [host_addr_width_lp-1:0] host_addr_i;
   logic acc_valid_o, acc_write_o, acc_ready_i;
   logic [bp_addr_width_lp-1:0] acc_addr_o;
   logic dram_req_valid_i, dram_req_write_i, dram_req_ready_o;
   logic [bp_addr_width_lp-1:0] dram_req_addr_i;
   logic hp_valid_o, hp_write_o, hp_ready_i;
   logic [bp_addr_width_lp-1:0] hp_addr_o;
   logic accel_reset_n_o;

   // reference model with expected {addr, write} queues, shadow registers and profile
   logic [31:0] seed;
   logic [32:0] acc_q[$];
   logic [32:0] hp_q[$];
   logic [31:0] shadow_reg[8];
   logic [profile_regions_lp-1:0] shadow_profile;
   logic host_fire, dram_fire, csr_fire, resp_seen;
   logic [31:0] resp_data;
   int errors, errs_at_start, tests_run, tests_failed, cycles;

   zynq_shell_top u_dut (.*);

   initial begin
      clk_i = 1'b0;
      forever #10 clk_i = ~clk_i;
   end

   always @(posedge clk_i) begin
      cycles <= cycles + 1;
      if (cycles >= timeout_lp) begin
         $display("timeout: no progress from the DUT after %0d cycles", cycles);
         $display("*** TEST FAILED ***");
         $finish;
      end
   end

   function automatic logic [15:0] rand16();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed[31:16];
   endfunction

   function automatic logic [31:0] rand_word();
      return {rand16(), rand16()};
   endfunction

   // window 0 goes to accelerator DRAM, window 2 to local space
   function automatic logic [31:0] host_window_addr(input logic [29:0] a);
      return (a[29] ? 32'h0000_0000 : 32'h8000_0000) | {4'h0, a[27:0]};
   endfunction

   function automatic logic [31:0] expected_read(input logic [2:0] idx);
      if (idx < 3)
         return shadow_reg[idx];
      else if (idx < 7)
         return shadow_profile[(idx - 3) * 32 +: 32];
      return 32'h0;
   endfunction

   task automatic report_error(input string msg);
      errors++;
      $display("ERROR %0t: %s", $time, msg);
   endtask

   // sample every handshake at the falling edge ahead of the edge that completes it
   task automatic next_cycle();
      logic [32:0] exp;
      @(negedge clk_i);
      host_fire = host_valid_i & host_ready_o;
      dram_fire = dram_req_valid_i & dram_req_ready_o;
      csr_fire  = csr_req_valid_i & csr_req_ready_o;
      resp_seen = csr_resp_valid_o & csr_resp_ready_i;
      resp_data = csr_resp_data_o;
      if (acc_valid_o && acc_ready_i) begin
         if (acc_q.size() == 0) begin
            report_error("host window sent a request that was never accepted");
         end else begin
            exp = acc_q.pop_front();
            if ({acc_addr_o, acc_write_o} !== exp)
               report_error($sformatf("host request got %h/%b expected %h/%b",
                                      acc_addr_o, acc_write_o, exp[32:1], exp[0]));
         end
      end
      if (hp_valid_o && hp_ready_i) begin
         if (hp_q.size() == 0) begin
            report_error("HP port sent a request that was never accepted");
         end else begin
            exp = hp_q.pop_front();
            if ({hp_addr_o, hp_write_o} !== exp)
               report_error($sformatf("HP request got %h/%b expected %h/%b",
                                      hp_addr_o, hp_write_o, exp[32:1], exp[0]));
         end
      end
      if (host_fire)
         acc_q.push_back({host_window_addr(host_addr_i), host_write_i});
      if (dram_fire) begin
         hp_q.push_back({(dram_req_addr_i ^ 32'h8000_0000) + shadow_reg[2], dram_req_write_i});
         if (shadow_reg[0][0])
            shadow_profile[dram_req_addr_i[29:23]] = 1'b1;
      end
      @(posedge clk_i);
      #2;
   endtask

   task automatic csr_access(input logic wr, input logic [2:0] idx, input logic [31:0] wd,
                             output logic [31:0] rd);
      csr_req_valid_i = 1'b1;
      csr_req_write_i = wr;
      csr_req_addr_i  = idx;
      csr_req_wdata_i = wd;
      do
         next_cycle();
      while (!csr_fire);
      csr_req_valid_i = 1'b0;
      do
         next_cycle();
      while (!resp_seen);
      rd = resp_data;
   endtask

   task automatic csr_write(input logic [2:0] idx, input logic [31:0] wd);
      logic [31:0] wr_resp;
      csr_access(1'b1, idx, wd, wr_resp);
      // only bit 0 of the flag registers exists
      if (idx < 2)
         shadow_reg[idx] = {31'b0, wd[0]};
      else if (idx == 2)
         shadow_reg[idx] = wd;
      if (!shadow_reg[0][0])
         shadow_profile = '0;
      if (accel_reset_n_o !== shadow_reg[0][0])
         report_error($sformatf("accel_reset_n_o is %b expected %b",
                                accel_reset_n_o, shadow_reg[0][0]));
   endtask

   task automatic check_read(input logic [2:0] idx);
      logic [31:0] got;
      logic [31:0] exp;
      csr_access(1'b0, idx, 32'h0, got);
      exp = expected_read(idx);
      if (got !== exp)
         report_error($sformatf("register %0d read %h expected %h", idx, got, exp));
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (errors == errs_at_start) begin
         $display("test %0d %s: passed", tests_run, name);
      end else begin
         tests_failed++;
         $display("test %0d %s: failed with %0d errors", tests_run, name,
                  errors - errs_at_start);
      end
      errs_at_start = errors;
   endtask

   initial begin
      int sent;
      logic [2:0] idx;
      seed = 32'ha19d;
      {csr_req_valid_i, csr_req_write_i, csr_req_addr_i, csr_req_wdata_i} = '0;
      {host_valid_i, host_write_i, host_addr_i, acc_ready_i} = '0;
      {dram_req_valid_i, dram_req_write_i, dram_req_addr_i, hp_ready_i} = '0;
      csr_resp_ready_i = 1'b1;
      shadow_profile = '0;
      foreach (shadow_reg[i])
         shadow_reg[i] = '0;
      rst_n_i = 1'b0;
      repeat (3) @(posedge clk_i);
      #2;
      rst_n_i = 1'b1;

      if (accel_reset_n_o !== 1'b0)
         report_error("accel_reset_n_o is high after reset");
      if (dram_req_ready_o !== 1'b0)
         report_error("dram_req_ready_o is high after reset");
      check_read(csr_reset_idx_lp);
      end_test("reset state");

      for (int i = 0; i < n_csr_lp; i++) begin
         idx = 3'(rand16());
         csr_write(idx, rand_word());
         check_read(idx);
      end
      check_read(3'd7);
      end_test("register write and read");

      sent = 0;
      while (sent < n_host_lp) begin
         next_cycle();
         if (host_fire) begin
            host_valid_i = 1'b0;
            sent++;
         end
         if (!host_valid_i && sent < n_host_lp && rand16() < 16'hc000) begin
            host_valid_i = 1'b1;
            host_addr_i  = 30'(rand_word());
            host_write_i = rand16() >= 16'h8000;
         end
         acc_ready_i = rand16() < 16'hc000;
      end
      while (acc_q.size() != 0) begin
         next_cycle();
         acc_ready_i = rand16() < 16'hc000;
      end
      acc_ready_i = 1'b1;
      end_test("host window");

      csr_write(csr_dram_base_idx_lp, rand_word());
      csr_write(csr_dram_valid_idx_lp, 32'h1);
      csr_write(csr_reset_idx_lp, 32'h1);
      sent = 0;
      for (int b = 0; b < n_burst_lp; b++) begin
         // a new base between bursts while the request port is idle
         if (b != 0)
            csr_write(csr_dram_base_idx_lp, rand_word());
         while (sent < (b + 1) * (n_dram_lp / n_burst_lp)) begin
            next_cycle();
            if (dram_fire) begin
               dram_req_valid_i = 1'b0;
               sent++;
            end
            if (!dram_req_valid_i && sent < (b + 1) * (n_dram_lp / n_burst_lp)
                && rand16() < 16'hc000) begin
               dram_req_valid_i = 1'b1;
               dram_req_addr_i  = rand_word();
               dram_req_write_i = rand16() >= 16'h8000;
            end
            hp_ready_i = rand16() < 16'hc000;
         end
      end
      while (hp_q.size() != 0) begin
         next_cycle();
         hp_ready_i = rand16() < 16'hc000;
      end
      hp_ready_i = 1'b1;
      end_test("DRAM rebase");

      for (int w = 0; w < 4; w++)
         check_read(3'(csr_profile_idx_lp + w));
      end_test("profile read");

      csr_write(csr_reset_idx_lp, 32'h0);
      for (int w = 0; w < 4; w++)
         check_read(3'(csr_profile_idx_lp + w));
      csr_write(csr_dram_valid_idx_lp, 32'h0);
      dram_req_valid_i = 1'b1;
      dram_req_addr_i  = rand_word();
      repeat (20) begin
         next_cycle();
         if (dram_req_ready_o !== 1'b0)
            report_error("dram_req_ready_o is high while DRAM is not allocated");
      end
      dram_req_valid_i = 1'b0;
      end_test("accelerator reset and DRAM release");

      $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule
